//--- rtl/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

	localparam int word_width = 16;
	localparam int num_regs = 4;
	localparam int btb_entries = 16;
	localparam int btb_index_width = $clog2(btb_entries);

	// Opcodes
	localparam logic [3:0] op_bne = 4'd0;
	localparam logic [3:0] op_beq = 4'd1;
	localparam logic [3:0] op_bgz = 4'd2;
	localparam logic [3:0] op_blz = 4'd3;
	localparam logic [3:0] op_adi = 4'd4;
	localparam logic [3:0] op_ori = 4'd5;
	localparam logic [3:0] op_lhi = 4'd6;
	localparam logic [3:0] op_lwd = 4'd7;
	localparam logic [3:0] op_swd = 4'd8;
	localparam logic [3:0] op_jmp = 4'd9;
	localparam logic [3:0] op_jal = 4'd10;
	localparam logic [3:0] op_rtype = 4'd15;

	// R-type function codes with the ALU ones in alu_op_e order
	localparam logic [5:0] fn_add = 6'd0;
	localparam logic [5:0] fn_sub = 6'd1;
	localparam logic [5:0] fn_and = 6'd2;
	localparam logic [5:0] fn_orr = 6'd3;
	localparam logic [5:0] fn_not = 6'd4;
	localparam logic [5:0] fn_tcp = 6'd5;
	localparam logic [5:0] fn_shl = 6'd6;
	localparam logic [5:0] fn_shr = 6'd7;
	localparam logic [5:0] fn_jpr = 6'd25;
	localparam logic [5:0] fn_jrl = 6'd26;
	localparam logic [5:0] fn_wwd = 6'd28;
	localparam logic [5:0] fn_hlt = 6'd29;

	// Operand B source with sign-extended immediates
	localparam logic [1:0] src_reg = 2'd0;
	localparam logic [1:0] src_imm = 2'd1;
	localparam logic [1:0] src_upper = 2'd2;

	// Destination register select
	localparam logic [1:0] dest_rd = 2'd0;
	localparam logic [1:0] dest_rt = 2'd1;
	localparam logic [1:0] dest_link = 2'd2;
	localparam logic [1:0] link_reg = 2'd2;

	// Forwarding source
	localparam logic [1:0] fwd_none = 2'd0;
	localparam logic [1:0] fwd_mem = 2'd1;
	localparam logic [1:0] fwd_wb = 2'd2;

	typedef enum logic [2:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_not,
		alu_tcp,
		alu_shl,
		alu_shr
	} alu_op_e;

	typedef struct packed {
		logic [3:0] opcode;
		logic [1:0] rs;
		logic [1:0] rt;
		union packed {
			struct packed {
				logic [1:0] rd;
				logic [5:0] funct;
			} r;
			logic [7:0] imm;
		} low;
	} reg_view_t;

	typedef struct packed {
		logic [3:0] opcode;
		logic [11:0] target;
	} jump_view_t;

	typedef union packed {
		reg_view_t rv;
		jump_view_t jv;
	} instr_u;

endpackage

`default_nettype wire

//--- rtl/alu.sv
`default_nettype none

module alu (
	input  logic [cpu_pkg::word_width-1:0] a,
	input  logic [cpu_pkg::word_width-1:0] b,
	input  cpu_pkg::alu_op_e               op,
	output logic [cpu_pkg::word_width-1:0] result
);
	import cpu_pkg::*;

	always_comb begin
		case (op)
			alu_add: begin
				result = a + b;
			end
			alu_sub: begin
				result = a - b;
			end
			alu_and: begin
				result = a & b;
			end
			alu_or: begin
				result = a | b;
			end
			alu_not: begin
				result = ~a;
			end
			alu_tcp: begin
				result = ~a + 1'b1;
			end
			alu_shl: begin
				result = {a[word_width-2:0], 1'b0};
			end
			default: begin
				// Arithmetic shift right by one
				result = {a[word_width-1], a[word_width-1:1]};
			end
		endcase
	end

endmodule

`default_nettype wire

//--- rtl/register_file.sv
`default_nettype none

module register_file (
	input  logic                           Clk,
	input  logic                           rst_n,
	input  logic [1:0]                     rs_addr,
	input  logic [1:0]                     rt_addr,
	input  logic [1:0]                     wr_addr,
	input  logic [cpu_pkg::word_width-1:0] wr_data,
	input  logic                           wr_en,
	output logic [cpu_pkg::word_width-1:0] rs_data,
	output logic [cpu_pkg::word_width-1:0] rt_data
);
	import cpu_pkg::*;

	logic [word_width-1:0] regs [num_regs];

	always_ff @(posedge Clk) begin
		if (!rst_n) begin
			regs <= '{default: '0};
		end else if (wr_en) begin
			regs[wr_addr] <= wr_data;
		end
	end

	// Write-through so decode sees the value retiring this cycle
	assign rs_data = (wr_en && wr_addr == rs_addr) ? wr_data : regs[rs_addr];
	assign rt_data = (wr_en && wr_addr == rt_addr) ? wr_data : regs[rt_addr];

endmodule

`default_nettype wire

//--- rtl/control.sv
`default_nettype none

module control (
	input  cpu_pkg::instr_u  instr,
	output cpu_pkg::alu_op_e alu_op,
	output logic [1:0]       alu_src,
	output logic [1:0]       reg_dest,
	output logic             reg_write,
	output logic             mem_read,
	output logic             mem_write,
	output logic             mem_to_reg,
	output logic             pc_to_reg,
	output logic             is_branch,
	output logic             is_jump,
	output logic             is_jump_reg,
	output logic             is_wwd,
	output logic             is_halt
);
	import cpu_pkg::*;

	always_comb begin
		alu_op = alu_add;
		alu_src = src_reg;
		reg_dest = dest_rd;
		reg_write = 1'b0;
		mem_read = 1'b0;
		mem_write = 1'b0;
		mem_to_reg = 1'b0;
		pc_to_reg = 1'b0;
		is_branch = 1'b0;
		is_jump = 1'b0;
		is_jump_reg = 1'b0;
		is_wwd = 1'b0;
		is_halt = 1'b0;
		case (instr.rv.opcode)
			op_bne, op_beq, op_bgz, op_blz: begin
				is_branch = 1'b1;
			end
			op_adi, op_ori, op_lhi: begin
				alu_op = (instr.rv.opcode == op_adi) ? alu_add : alu_or;
				alu_src = (instr.rv.opcode == op_lhi) ? src_upper : src_imm;
				reg_dest = dest_rt;
				reg_write = 1'b1;
			end
			op_lwd: begin
				alu_src = src_imm;
				reg_dest = dest_rt;
				reg_write = 1'b1;
				mem_read = 1'b1;
				mem_to_reg = 1'b1;
			end
			op_swd: begin
				alu_src = src_imm;
				mem_write = 1'b1;
			end
			op_jmp, op_jal: begin
				is_jump = 1'b1;
				reg_write = (instr.rv.opcode == op_jal);
				pc_to_reg = (instr.rv.opcode == op_jal);
				reg_dest = dest_link;
			end
			op_rtype: begin
				case (instr.rv.low.r.funct)
					fn_add, fn_sub, fn_and, fn_orr, fn_not, fn_tcp, fn_shl, fn_shr: begin
						alu_op = alu_op_e'(instr.rv.low.r.funct[2:0]);
						reg_write = 1'b1;
					end
					fn_jpr, fn_jrl: begin
						is_jump_reg = 1'b1;
						reg_write = (instr.rv.low.r.funct == fn_jrl);
						pc_to_reg = (instr.rv.low.r.funct == fn_jrl);
						reg_dest = dest_link;
					end
					fn_wwd: begin
						is_wwd = 1'b1;
					end
					fn_hlt: begin
						is_halt = 1'b1;
					end
					default: begin
						reg_write = 1'b0;
					end
				endcase
			end
			default: begin
				reg_write = 1'b0;
			end
		endcase
	end

endmodule

`default_nettype wire

//--- rtl/forwarding_unit.sv
`default_nettype none

module forwarding_unit (
	input  logic [1:0] ex_rs,
	input  logic [1:0] ex_rt,
	input  logic [1:0] mem_dest,
	input  logic [1:0] wb_dest,
	input  logic       mem_reg_write,
	input  logic       wb_reg_write,
	output logic [1:0] fwd_a,
	output logic [1:0] fwd_b
);
	import cpu_pkg::*;

	// Memory stage holds the younger result, so it wins
	always_comb begin
		if (mem_reg_write && mem_dest == ex_rs) begin
			fwd_a = fwd_mem;
		end else if (wb_reg_write && wb_dest == ex_rs) begin
			fwd_a = fwd_wb;
		end else begin
			fwd_a = fwd_none;
		end
		if (mem_reg_write && mem_dest == ex_rt) begin
			fwd_b = fwd_mem;
		end else if (wb_reg_write && wb_dest == ex_rt) begin
			fwd_b = fwd_wb;
		end else begin
			fwd_b = fwd_none;
		end
	end

endmodule

`default_nettype wire

//--- rtl/btb.sv
`default_nettype none

module btb (
	input  logic                           Clk,
	input  logic                           rst_n,
	input  logic [cpu_pkg::word_width-1:0] fetch_pc,
	output logic [cpu_pkg::word_width-1:0] pred_pc,
	input  logic                           update,
	input  logic [cpu_pkg::word_width-1:0] update_pc,
	input  logic [cpu_pkg::word_width-1:0] update_target,
	input  logic                           update_taken
);
	import cpu_pkg::*;

	localparam int tag_width = word_width - btb_index_width;

	logic [btb_entries-1:0] valid;
	logic [tag_width-1:0] tags [btb_entries];
	logic [word_width-1:0] targets [btb_entries];

	logic [btb_index_width-1:0] fetch_idx;
	logic [btb_index_width-1:0] upd_idx;
	logic hit;

	assign fetch_idx = fetch_pc[btb_index_width-1:0];
	assign upd_idx = update_pc[btb_index_width-1:0];
	assign hit = valid[fetch_idx] && tags[fetch_idx] == fetch_pc[word_width-1:btb_index_width];
	assign pred_pc = hit ? targets[fetch_idx] : fetch_pc + 1'b1;

	// Not-taken outcome drops the entry
	always_ff @(posedge Clk) begin
		if (!rst_n) begin
			valid <= '0;
		end else if (update) begin
			valid[upd_idx] <= update_taken;
		end
	end

	always_ff @(posedge Clk) begin
		if (update && update_taken) begin
			tags[upd_idx] <= update_pc[word_width-1:btb_index_width];
			targets[upd_idx] <= update_target;
		end
	end

endmodule

`default_nettype wire

//--- rtl/cpu.sv
`default_nettype none

module cpu (
	input  logic                           Clk,
	input  logic                           rst_n,
	output logic [cpu_pkg::word_width-1:0] inst_addr,
	input  logic [cpu_pkg::word_width-1:0] inst_data,
	output logic [cpu_pkg::word_width-1:0] data_addr,
	output logic [cpu_pkg::word_width-1:0] data_wdata,
	output logic                           data_read,
	output logic                           data_write,
	input  logic [cpu_pkg::word_width-1:0] data_rdata,
	output logic [cpu_pkg::word_width-1:0] output_port,
	output logic                           wwd_valid,
	output logic [cpu_pkg::word_width-1:0] num_inst,
	output logic                           is_halted
);
	import cpu_pkg::*;

	logic [word_width-1:0] pc, pred_pc;
	logic halted_q;

	// IF/ID
	logic if_id_valid;
	instr_u if_id_instr;
	logic [word_width-1:0] if_id_pc, if_id_pred_pc;

	// Decode
	alu_op_e id_alu_op;
	logic [1:0] id_alu_src, id_reg_dest;
	logic id_reg_write, id_mem_read, id_mem_write, id_mem_to_reg, id_pc_to_reg;
	logic id_is_branch, id_is_jump, id_is_jump_reg, id_is_wwd, id_is_halt;
	logic [word_width-1:0] id_rs_data, id_rt_data;
	logic uses_rs, uses_rt, load_use;

	// ID/EX
	logic id_ex_valid;
	instr_u id_ex_instr;
	logic [word_width-1:0] id_ex_pc, id_ex_pred_pc, id_ex_rs_data, id_ex_rt_data;
	alu_op_e id_ex_alu_op;
	logic [1:0] id_ex_alu_src, id_ex_reg_dest;
	logic id_ex_reg_write, id_ex_mem_read, id_ex_mem_write, id_ex_mem_to_reg, id_ex_pc_to_reg;
	logic id_ex_is_branch, id_ex_is_jump, id_ex_is_jump_reg, id_ex_is_wwd, id_ex_is_halt;

	// Execute
	logic [1:0] fwd_a, fwd_b, ex_dest;
	logic [word_width-1:0] rs_val, rt_val, imm_ext, alu_a, alu_b, alu_result, ex_result;
	logic [word_width-1:0] ex_pc_plus_one, branch_target, jump_target, next_pc;
	logic branch_taken, mispredict, halt_ex, btb_update;

	// EX/MEM and MEM/WB
	logic ex_mem_valid, ex_mem_reg_write, ex_mem_mem_read, ex_mem_mem_write, ex_mem_mem_to_reg;
	logic [word_width-1:0] ex_mem_result, ex_mem_wdata;
	logic [1:0] ex_mem_dest;
	logic mem_wb_valid, mem_wb_reg_write, mem_wb_mem_to_reg;
	logic [word_width-1:0] mem_wb_result, mem_wb_rdata, wb_data;
	logic [1:0] mem_wb_dest;

	assign inst_addr = pc;

	btb i_btb (
		.Clk(Clk),
		.rst_n(rst_n),
		.fetch_pc(pc),
		.pred_pc(pred_pc),
		.update(btb_update),
		.update_pc(id_ex_pc),
		.update_target(next_pc),
		.update_taken(id_ex_is_jump || id_ex_is_jump_reg || branch_taken)
	);

	control i_control (
		.instr(if_id_instr),
		.alu_op(id_alu_op),
		.alu_src(id_alu_src),
		.reg_dest(id_reg_dest),
		.reg_write(id_reg_write),
		.mem_read(id_mem_read),
		.mem_write(id_mem_write),
		.mem_to_reg(id_mem_to_reg),
		.pc_to_reg(id_pc_to_reg),
		.is_branch(id_is_branch),
		.is_jump(id_is_jump),
		.is_jump_reg(id_is_jump_reg),
		.is_wwd(id_is_wwd),
		.is_halt(id_is_halt)
	);

	register_file i_register_file (
		.Clk(Clk),
		.rst_n(rst_n),
		.rs_addr(if_id_instr.rv.rs),
		.rt_addr(if_id_instr.rv.rt),
		.wr_addr(mem_wb_dest),
		.wr_data(wb_data),
		.wr_en(mem_wb_valid && mem_wb_reg_write),
		.rs_data(id_rs_data),
		.rt_data(id_rt_data)
	);

	// Conservative operand use for the load-use check
	assign uses_rs = !id_is_jump;
	assign uses_rt = id_mem_write || id_is_branch ||
		(id_reg_write && id_reg_dest == dest_rd && !id_pc_to_reg);
	assign load_use = if_id_valid && id_ex_valid && id_ex_mem_read &&
		((uses_rs && ex_dest == if_id_instr.rv.rs) || (uses_rt && ex_dest == if_id_instr.rv.rt));

	forwarding_unit i_forwarding_unit (
		.ex_rs(id_ex_instr.rv.rs),
		.ex_rt(id_ex_instr.rv.rt),
		.mem_dest(ex_mem_dest),
		.wb_dest(mem_wb_dest),
		.mem_reg_write(ex_mem_valid && ex_mem_reg_write),
		.wb_reg_write(mem_wb_valid && mem_wb_reg_write),
		.fwd_a(fwd_a),
		.fwd_b(fwd_b)
	);

	assign wb_data = mem_wb_mem_to_reg ? mem_wb_rdata : mem_wb_result;
	assign rs_val = (fwd_a == fwd_mem) ? ex_mem_result : (fwd_a == fwd_wb) ? wb_data : id_ex_rs_data;
	assign rt_val = (fwd_b == fwd_mem) ? ex_mem_result : (fwd_b == fwd_wb) ? wb_data : id_ex_rt_data;
	assign imm_ext = {{(word_width - 8){id_ex_instr.rv.low.imm[7]}}, id_ex_instr.rv.low.imm};

	// LHI is the upper immediate ORed onto zero
	assign alu_a = (id_ex_alu_src == src_upper) ? '0 : rs_val;
	assign alu_b = (id_ex_alu_src == src_imm) ? imm_ext :
		(id_ex_alu_src == src_upper) ? {id_ex_instr.rv.low.imm, 8'h00} : rt_val;

	alu i_alu (
		.a(alu_a),
		.b(alu_b),
		.op(id_ex_alu_op),
		.result(alu_result)
	);

	assign ex_pc_plus_one = id_ex_pc + 1'b1;
	assign ex_result = id_ex_pc_to_reg ? ex_pc_plus_one : alu_result;
	assign ex_dest = (id_ex_reg_dest == dest_rt) ? id_ex_instr.rv.rt :
		(id_ex_reg_dest == dest_link) ? link_reg : id_ex_instr.rv.low.r.rd;

	always_comb begin
		case (id_ex_instr.rv.opcode)
			op_bne: branch_taken = rs_val != rt_val;
			op_beq: branch_taken = rs_val == rt_val;
			op_bgz: branch_taken = $signed(rs_val) > 0;
			op_blz: branch_taken = $signed(rs_val) < 0;
			default: branch_taken = 1'b0;
		endcase
	end

	// Resolved next PC is checked against the prediction made in fetch
	assign branch_target = ex_pc_plus_one + imm_ext;
	assign jump_target = {ex_pc_plus_one[word_width-1:12], id_ex_instr.jv.target};
	assign next_pc = id_ex_is_jump ? jump_target : id_ex_is_jump_reg ? rs_val :
		branch_taken ? branch_target : ex_pc_plus_one;
	assign mispredict = id_ex_valid && next_pc != id_ex_pred_pc;
	assign btb_update = id_ex_valid && (id_ex_is_branch || id_ex_is_jump || id_ex_is_jump_reg);
	assign halt_ex = id_ex_valid && id_ex_is_halt;

	assign wwd_valid = id_ex_valid && id_ex_is_wwd;
	assign output_port = rs_val;
	assign is_halted = halted_q;

	assign data_read = ex_mem_valid && ex_mem_mem_read;
	assign data_write = ex_mem_valid && ex_mem_mem_write;
	assign data_addr = ex_mem_result;
	assign data_wdata = ex_mem_wdata;

	always_ff @(posedge Clk) begin
		if (!rst_n) begin
			pc <= '0;
			halted_q <= 1'b0;
			num_inst <= '0;
			if_id_valid <= 1'b0;
			id_ex_valid <= 1'b0;
			ex_mem_valid <= 1'b0;
			mem_wb_valid <= 1'b0;
		end else begin
			// Halt freezes fetch and drops the two younger slots
			if (halt_ex || halted_q) begin
				if_id_valid <= 1'b0;
			end else if (mispredict) begin
				pc <= next_pc;
				if_id_valid <= 1'b0;
			end else if (!load_use) begin
				pc <= pred_pc;
				if_id_valid <= 1'b1;
			end
			id_ex_valid <= if_id_valid && !load_use && !mispredict && !halt_ex;
			ex_mem_valid <= id_ex_valid;
			mem_wb_valid <= ex_mem_valid;
			if (halt_ex) begin
				halted_q <= 1'b1;
			end
			if (id_ex_valid) begin
				num_inst <= num_inst + 1'b1;
			end
		end
	end

	always_ff @(posedge Clk) begin
		if (!load_use) begin
			if_id_instr <= inst_data;
			if_id_pc <= pc;
			if_id_pred_pc <= pred_pc;
		end
		id_ex_instr <= if_id_instr;
		id_ex_pc <= if_id_pc;
		id_ex_pred_pc <= if_id_pred_pc;
		id_ex_rs_data <= id_rs_data;
		id_ex_rt_data <= id_rt_data;
		id_ex_alu_op <= id_alu_op;
		id_ex_alu_src <= id_alu_src;
		id_ex_reg_dest <= id_reg_dest;
		id_ex_reg_write <= id_reg_write;
		id_ex_mem_read <= id_mem_read;
		id_ex_mem_write <= id_mem_write;
		id_ex_mem_to_reg <= id_mem_to_reg;
		id_ex_pc_to_reg <= id_pc_to_reg;
		id_ex_is_branch <= id_is_branch;
		id_ex_is_jump <= id_is_jump;
		id_ex_is_jump_reg <= id_is_jump_reg;
		id_ex_is_wwd <= id_is_wwd;
		id_ex_is_halt <= id_is_halt;
		ex_mem_result <= ex_result;
		ex_mem_wdata <= rt_val;
		ex_mem_dest <= ex_dest;
		ex_mem_reg_write <= id_ex_reg_write;
		ex_mem_mem_read <= id_ex_mem_read;
		ex_mem_mem_write <= id_ex_mem_write;
		ex_mem_mem_to_reg <= id_ex_mem_to_reg;
		mem_wb_result <= ex_mem_result;
		mem_wb_rdata <= data_rdata;
		mem_wb_dest <= ex_mem_dest;
		mem_wb_reg_write <= ex_mem_reg_write;
		mem_wb_mem_to_reg <= ex_mem_mem_to_reg;
	end

endmodule

`default_nettype wire

//--- dv/cpu_asserts.sv
`default_nettype none

module cpu_asserts (
	input logic                           Clk,
	input logic                           rst_n,
	input logic                           data_read,
	input logic                           data_write,
	input logic                           wwd_valid,
	input logic                           is_halted,
	input logic [cpu_pkg::word_width-1:0] num_inst
);
	int unsigned failures = 0;

	read_write_exclusive: assert property (@(posedge Clk) disable iff (!rst_n)
		!(data_read && data_write))
	else begin
		failures++;
		$error("data_read and data_write are high in the same cycle");
	end

	// Strobes quiet right after a reset edge
	quiet_after_reset: assert property (@(posedge Clk)
		!rst_n |=> (!wwd_valid && !data_read && !data_write))
	else begin
		failures++;
		$error("A strobe is high in the cycle after reset");
	end

	halt_sticky: assert property (@(posedge Clk) disable iff (!rst_n)
		is_halted |=> is_halted)
	else begin
		failures++;
		$error("is_halted dropped without a reset");
	end

	count_frozen: assert property (@(posedge Clk) disable iff (!rst_n)
		is_halted |=> $stable(num_inst))
	else begin
		failures++;
		$error("num_inst changed after the halt");
	end

endmodule

bind cpu cpu_asserts i_cpu_asserts (.*);

`default_nettype wire

//--- dv/cpu_tb.sv
`default_nettype none

module cpu_tb;
	import cpu_pkg::*;

	logic Clk = 1'b0;
	logic rst_n;
	logic [word_width-1:0] inst_addr;
	logic [word_width-1:0] inst_data;
	logic [word_width-1:0] data_addr;
	logic [word_width-1:0] data_wdata;
	logic [word_width-1:0] data_rdata;
	logic data_read;
	logic data_write;
	logic [word_width-1:0] output_port;
	logic [word_width-1:0] num_inst;
	logic wwd_valid;
	logic is_halted;

	instr_u imem [256];
	logic [word_width-1:0] dmem [256];
	logic [15:0] lfsr_state = 16'd80;
	int wp = 0;
	int exp_count = 0;
	int wwd_seen = 0;
	int value_errors = 0;
	int other_errors = 0;
	logic [word_width-1:0] exp_out [$];
	logic [word_width-1:0] exp_addr [$];
	logic [word_width-1:0] exp_data [$];

	cpu i_cpu (
		.Clk(Clk),
		.rst_n(rst_n),
		.inst_addr(inst_addr),
		.inst_data(inst_data),
		.data_addr(data_addr),
		.data_wdata(data_wdata),
		.data_read(data_read),
		.data_write(data_write),
		.data_rdata(data_rdata),
		.output_port(output_port),
		.wwd_valid(wwd_valid),
		.num_inst(num_inst),
		.is_halted(is_halted)
	);

	always #5 Clk = ~Clk;

	// Zero-wait memories
	assign inst_data = imem[inst_addr[7:0]];
	// Load data only appears under the read strobe
	assign data_rdata = data_read ? dmem[data_addr[7:0]] : 'x;

	always @(posedge Clk) begin
		if (data_write) begin
			dmem[data_addr[7:0]] <= data_wdata;
		end
	end

	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	function automatic logic [15:0] random_bits(input int n);
		logic [15:0] v;
		int i;
		v = '0;
		for (i = 0; i < n; i++) begin
			v = {v[14:0], lfsr_state[0]};
			lfsr_state = lfsr_next(lfsr_state);
		end
		return v;
	endfunction

	function automatic instr_u imm_instr(logic [3:0] op, logic [1:0] rs, logic [1:0] rt,
		logic [7:0] imm);
		instr_u w;
		w = '0;
		w.rv.opcode = op;
		w.rv.rs = rs;
		w.rv.rt = rt;
		w.rv.low.imm = imm;
		return w;
	endfunction

	function automatic instr_u reg_instr(logic [1:0] rs, logic [1:0] rt, logic [1:0] rd,
		logic [5:0] funct);
		instr_u w;
		w = '0;
		w.rv.opcode = op_rtype;
		w.rv.rs = rs;
		w.rv.rt = rt;
		w.rv.low.r.rd = rd;
		w.rv.low.r.funct = funct;
		return w;
	endfunction

	function automatic instr_u jump_instr(logic [3:0] op, logic [11:0] target);
		instr_u w;
		w.jv.opcode = op;
		w.jv.target = target;
		return w;
	endfunction

	task automatic emit(input instr_u w);
		imem[wp] = w;
		wp++;
	endtask

	task automatic value_mismatch(input string name, input logic [15:0] expected,
		input logic [15:0] actual);
		value_errors++;
		$display("Fail %s: expected %h, actual %h", name, expected, actual);
	endtask

	task automatic note_failure(input string what);
		other_errors++;
		$display("%s", what);
	endtask

	task automatic load_program();
		logic [5:0] alu_fns [8];
		int f;
		alu_fns = '{fn_add, fn_sub, fn_and, fn_orr, fn_not, fn_tcp, fn_shl, fn_shr};
		emit(imm_instr(op_lwd, 0, 1, 0));
		emit(imm_instr(op_lwd, 0, 3, 1));
		// Load-use on r3
		emit(reg_instr(1, 3, 0, fn_add));
		emit(reg_instr(0, 0, 0, fn_wwd));
		for (f = 0; f < 8; f++) begin
			emit(reg_instr(0, 1, 0, alu_fns[f]));
			emit(reg_instr(0, 0, 0, fn_wwd));
		end
		emit(imm_instr(op_lhi, 0, 1, 8'(random_bits(8))));
		emit(imm_instr(op_ori, 1, 1, 8'(random_bits(8))));
		emit(imm_instr(op_adi, 1, 1, 8'(random_bits(8))));
		emit(reg_instr(1, 0, 0, fn_wwd));
		emit(imm_instr(op_lhi, 0, 3, 0));
		emit(imm_instr(op_swd, 3, 1, 8));
		emit(imm_instr(op_lwd, 3, 0, 8));
		emit(reg_instr(0, 0, 0, fn_wwd));
		emit(imm_instr(op_lwd, 3, 0, 2));
		emit(reg_instr(0, 1, 0, fn_add));
		emit(reg_instr(0, 0, 0, fn_wwd));
		// Countdown loop at 32
		emit(imm_instr(op_adi, 3, 1, 4));
		emit(reg_instr(1, 0, 0, fn_wwd));
		emit(imm_instr(op_adi, 1, 1, 8'hFF));
		emit(imm_instr(op_bne, 1, 3, 8'hFD));
		emit(reg_instr(1, 0, 0, fn_wwd));
		emit(imm_instr(op_beq, 1, 3, 1));
		emit(reg_instr(3, 0, 0, fn_wwd));
		emit(imm_instr(op_adi, 3, 1, 8'hFE));
		emit(imm_instr(op_bgz, 1, 0, 1));
		emit(reg_instr(1, 0, 0, fn_wwd));
		emit(imm_instr(op_blz, 1, 0, 1));
		emit(reg_instr(3, 0, 0, fn_wwd));
		emit(imm_instr(op_adi, 3, 0, 5));
		emit(imm_instr(op_bgz, 0, 0, 1));
		emit(reg_instr(0, 0, 0, fn_wwd));
		emit(imm_instr(op_blz, 0, 0, 1));
		emit(reg_instr(0, 0, 0, fn_wwd));
		// Jumps from 48 with subroutines at 53 and 59
		emit(jump_instr(op_jmp, 50));
		emit(reg_instr(0, 0, 0, fn_wwd));
		emit(jump_instr(op_jal, 53));
		emit(reg_instr(0, 0, 0, fn_wwd));
		emit(jump_instr(op_jmp, 62));
		emit(reg_instr(2, 0, 0, fn_wwd));
		emit(reg_instr(2, 3, 0, fn_add));
		emit(imm_instr(op_adi, 3, 1, 59));
		emit(reg_instr(1, 0, 0, fn_jrl));
		emit(reg_instr(0, 0, 0, fn_jpr));
		emit(reg_instr(1, 0, 0, fn_wwd));
		emit(reg_instr(2, 0, 0, fn_wwd));
		emit(reg_instr(2, 0, 0, fn_jpr));
		emit(reg_instr(1, 0, 0, fn_wwd));
		emit(reg_instr(1, 0, 0, fn_wwd));
		emit(reg_instr(0, 0, 0, fn_hlt));
		emit(reg_instr(1, 0, 0, fn_wwd));
	endtask

	// Instruction-set model stepping one instruction at a time
	task automatic run_model();
		logic [15:0] r [4];
		logic [15:0] m [256];
		logic [15:0] pc, a, b, imm, next, ea;
		instr_u w;
		logic done;
		int i;
		for (i = 0; i < 256; i++) begin
			m[i] = dmem[i];
		end
		r = '{default: '0};
		pc = '0;
		done = 1'b0;
		while (!done && exp_count < 1000) begin
			w = imem[pc[7:0]];
			a = r[w.rv.rs];
			b = r[w.rv.rt];
			imm = {{8{w.rv.low.imm[7]}}, w.rv.low.imm};
			next = pc + 16'd1;
			exp_count++;
			case (w.rv.opcode)
				op_bne: if (a != b) next = pc + 16'd1 + imm;
				op_beq: if (a == b) next = pc + 16'd1 + imm;
				op_bgz: if ($signed(a) > 0) next = pc + 16'd1 + imm;
				op_blz: if ($signed(a) < 0) next = pc + 16'd1 + imm;
				op_adi: r[w.rv.rt] = a + imm;
				op_ori: r[w.rv.rt] = a | imm;
				op_lhi: r[w.rv.rt] = {w.rv.low.imm, 8'h00};
				op_lwd: begin
					ea = a + imm;
					r[w.rv.rt] = m[ea[7:0]];
				end
				op_swd: begin
					ea = a + imm;
					m[ea[7:0]] = b;
					exp_addr.push_back(ea);
					exp_data.push_back(b);
				end
				op_jmp: next = {next[15:12], w.jv.target};
				op_jal: begin
					r[2] = next;
					next = {next[15:12], w.jv.target};
				end
				op_rtype: begin
					case (w.rv.low.r.funct)
						fn_add: r[w.rv.low.r.rd] = a + b;
						fn_sub: r[w.rv.low.r.rd] = a - b;
						fn_and: r[w.rv.low.r.rd] = a & b;
						fn_orr: r[w.rv.low.r.rd] = a | b;
						fn_not: r[w.rv.low.r.rd] = ~a;
						fn_tcp: r[w.rv.low.r.rd] = -a;
						fn_shl: r[w.rv.low.r.rd] = a << 1;
						fn_shr: r[w.rv.low.r.rd] = $signed(a) >>> 1;
						fn_jpr: next = a;
						fn_jrl: begin
							r[2] = next;
							next = a;
						end
						fn_wwd: exp_out.push_back(a);
						fn_hlt: done = 1'b1;
						default: ;
					endcase
				end
				default: ;
			endcase
			pc = next;
		end
	endtask

	always @(negedge Clk) begin
		if (wwd_valid) begin
			if (exp_out.size() == 0) begin
				note_failure($sformatf("Unexpected WWD output %h after the last expected one",
					output_port));
			end else begin
				assert (output_port == exp_out[0])
				else value_mismatch($sformatf("wwd output %0d", wwd_seen), exp_out[0], output_port);
				void'(exp_out.pop_front());
			end
			wwd_seen++;
		end
		if (data_write) begin
			if (exp_addr.size() == 0) begin
				note_failure("Unexpected store with no store left in the program");
			end else begin
				assert (data_addr == exp_addr[0])
				else value_mismatch("store address", exp_addr[0], data_addr);
				assert (data_wdata == exp_data[0])
				else value_mismatch("store data", exp_data[0], data_wdata);
				void'(exp_addr.pop_front());
				void'(exp_data.pop_front());
			end
		end
	end

	initial begin
		int i;
		int cycles;
		rst_n = 1'b0;
		for (i = 0; i < 256; i++) begin
			imem[i] = reg_instr(0, 0, 0, fn_hlt);
			dmem[i] = random_bits(16);
		end
		load_program();
		run_model();
		repeat (2) @(negedge Clk);
		rst_n = 1'b1;
		cycles = 0;
		while (!is_halted && cycles < 2000) begin
			@(negedge Clk);
			cycles++;
		end
		if (!is_halted) begin
			note_failure("Timed out waiting for is_halted after 2000 cycles");
		end
		// Nothing may follow the halt
		repeat (8) @(negedge Clk);
		assert (exp_out.size() == 0)
		else note_failure($sformatf("%0d expected WWD outputs never appeared", exp_out.size()));
		assert (exp_addr.size() == 0)
		else note_failure($sformatf("%0d expected stores never appeared", exp_addr.size()));
		assert (num_inst == 16'(exp_count))
		else value_mismatch("num_inst", 16'(exp_count), num_inst);
		$display("Errors: value %0d, other %0d, assertion %0d", value_errors, other_errors,
			i_cpu.i_cpu_asserts.failures);
		if (value_errors == 0 && other_errors == 0 && i_cpu.i_cpu_asserts.failures == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- cpu.f
rtl/cpu_pkg.sv
rtl/alu.sv
rtl/register_file.sv
rtl/control.sv
rtl/forwarding_unit.sv
rtl/btb.sv
rtl/cpu.sv
dv/cpu_asserts.sv
dv/cpu_tb.sv

//--- Bender.yml
package:
  name: cpu

sources:
  - rtl/cpu_pkg.sv
  - rtl/alu.sv
  - rtl/register_file.sv
  - rtl/control.sv
  - rtl/forwarding_unit.sv
  - rtl/btb.sv
  - rtl/cpu.sv
  - target: simulation
    files:
      - dv/cpu_asserts.sv
      - dv/cpu_tb.sv
